// File: common/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    // datapath and register file
    localparam int XLEN           = 64;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int NUM_REGS       = 2 ** REG_ADDR_WIDTH;

    // data RAM geometry, one entry per doubleword
    localparam int DMEM_DEPTH = 256;
    localparam int DMEM_AW    = 8;
    localparam int BOFF_W     = 3;  // byte offset inside a doubleword

    // instruction class
    localparam int OP_WIDTH = 2;
    localparam logic [OP_WIDTH-1:0] OP_ALU   = 2'd0;
    localparam logic [OP_WIDTH-1:0] OP_LOAD  = 2'd1;
    localparam logic [OP_WIDTH-1:0] OP_STORE = 2'd2;

    // load kind, signed kinds first
    localparam int LK_WIDTH = 3;
    localparam logic [LK_WIDTH-1:0] LK_B  = 3'd0;
    localparam logic [LK_WIDTH-1:0] LK_H  = 3'd1;
    localparam logic [LK_WIDTH-1:0] LK_W  = 3'd2;
    localparam logic [LK_WIDTH-1:0] LK_D  = 3'd3;
    localparam logic [LK_WIDTH-1:0] LK_BU = 3'd4;
    localparam logic [LK_WIDTH-1:0] LK_HU = 3'd5;
    localparam logic [LK_WIDTH-1:0] LK_WU = 3'd6;

    // store size
    localparam int SZ_WIDTH = 2;
    localparam logic [SZ_WIDTH-1:0] SZ_B = 2'd0;
    localparam logic [SZ_WIDTH-1:0] SZ_H = 2'd1;
    localparam logic [SZ_WIDTH-1:0] SZ_W = 2'd2;
    localparam logic [SZ_WIDTH-1:0] SZ_D = 2'd3;

    // one memory doubleword, seen as lanes of any access size
    typedef union packed {
        logic [7:0][7:0]  b;  // lane 0 is the lowest address
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
        logic [XLEN-1:0]  d;
    } dword_u;

endpackage

`default_nettype wire

// File: common/mem_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_wb_if import rvseed_pkg::*; ();

    logic                      valid;
    logic                      reg_wen;
    logic [REG_ADDR_WIDTH-1:0] reg_waddr;
    logic [XLEN-1:0]           alu_res;
    dword_u                    load_data;  // raw RAM word, lane picked in WB
    logic                      is_load;
    logic [LK_WIDTH-1:0]       load_kind;
    logic [BOFF_W-1:0]         byte_off;
    logic                      ebreak;

    modport producer (
        output valid, reg_wen, reg_waddr, alu_res, load_data,
        output is_load, load_kind, byte_off, ebreak
    );

    modport consumer (
        input valid, reg_wen, reg_waddr, alu_res, load_data,
        input is_load, load_kind, byte_off, ebreak
    );

endinterface

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import rvseed_pkg::*; (
    input  logic               clk,
    input  logic               we_i,
    input  logic [7:0]         wmask_i,  // one bit per byte lane
    input  logic [DMEM_AW-1:0] widx_i,
    input  dword_u             wdata_i,
    input  logic [DMEM_AW-1:0] ridx_i,
    output dword_u             rdata_o
);

    dword_u mem [DMEM_DEPTH];

    // byte-masked write, lanes outside the mask keep their old value
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask_i[i]) begin
                    mem[widx_i].b[i] <= wdata_i.b[i];
                end
            end
        end
    end

    assign rdata_o = mem[ridx_i];  // async read

    // a store always touches at least one lane
    a_wmask_nonzero: assert property (
        @(posedge clk) we_i |-> (wmask_i != 8'h00)
    ) else $error("data_ram: write with empty byte mask");

endmodule

`default_nettype wire

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_i,
    input  logic [OP_WIDTH-1:0]       op_i,
    input  logic                      reg_wen_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [XLEN-1:0]           alu_res_i,    // also the memory address
    input  logic [XLEN-1:0]           store_data_i,
    input  logic [SZ_WIDTH-1:0]       store_size_i,
    input  logic [LK_WIDTH-1:0]       load_kind_i,
    input  logic                      ebreak_i,
    mem_wb_if.producer                mw
);

    logic [BOFF_W-1:0]  off;
    logic [DMEM_AW-1:0] word_idx;
    logic               is_store;
    logic [7:0]         wmask;
    dword_u             wdata;
    dword_u             rdata;
    logic               st_misalign;
    logic               ld_misalign;

    assign off      = alu_res_i[BOFF_W-1:0];
    assign word_idx = alu_res_i[BOFF_W+DMEM_AW-1:BOFF_W];
    assign is_store = valid_i && (op_i == OP_STORE);

    // lane mask and replicated data; the mask picks the lanes that land
    always_comb begin
        wmask = 8'h00;
        wdata = '0;
        case (store_size_i)
            SZ_B: begin
                wmask  = 8'b0000_0001 << off;
                wdata.b = {8{store_data_i[7:0]}};
            end
            SZ_H: begin
                wmask  = 8'b0000_0011 << off;
                wdata.h = {4{store_data_i[15:0]}};
            end
            SZ_W: begin
                wmask  = 8'b0000_1111 << off;
                wdata.w = {2{store_data_i[31:0]}};
            end
            default: begin  // SZ_D
                wmask  = 8'hff;
                wdata.d = store_data_i;
            end
        endcase
    end

    data_ram u_data_ram (
        .clk     (clk),
        .we_i    (is_store),
        .wmask_i (wmask),
        .widx_i  (word_idx),
        .wdata_i (wdata),
        .ridx_i  (word_idx),
        .rdata_o (rdata)
    );

    assign mw.valid     = valid_i;
    assign mw.reg_wen   = valid_i && reg_wen_i && (rd_i != '0)
                          && ((op_i == OP_ALU) || (op_i == OP_LOAD));
    assign mw.reg_waddr = rd_i;
    assign mw.alu_res   = alu_res_i;
    assign mw.load_data = rdata;
    assign mw.is_load   = (op_i == OP_LOAD);
    assign mw.load_kind = load_kind_i;
    assign mw.byte_off  = off;
    assign mw.ebreak    = ebreak_i;

    // natural alignment checks, only feed the assertions
    always_comb begin
        case (store_size_i)
            SZ_H:    st_misalign = off[0];
            SZ_W:    st_misalign = |off[1:0];
            SZ_D:    st_misalign = |off;
            default: st_misalign = 1'b0;
        endcase
        case (load_kind_i)
            LK_H, LK_HU: ld_misalign = off[0];
            LK_W, LK_WU: ld_misalign = |off[1:0];
            LK_D:        ld_misalign = |off;
            default:     ld_misalign = 1'b0;
        endcase
    end

    a_store_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) is_store |-> !st_misalign
    ) else $error("mem_stage: misaligned store at %h", alu_res_i);

    a_load_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_i && op_i == OP_LOAD) |-> !ld_misalign
    ) else $error("mem_stage: misaligned load at %h", alu_res_i);

    a_store_no_wen: assert property (
        @(posedge clk) disable iff (!rst_n) is_store |-> !mw.reg_wen
    ) else $error("mem_stage: store requested a register write");

endmodule

`default_nettype wire

// File: hdl/mem_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_regs import rvseed_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    mem_wb_if.consumer in_i,
    mem_wb_if.producer out_o
);

    // whole bundle moves every cycle, no enable
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_o.valid     <= 1'b0;
            out_o.reg_wen   <= 1'b0;
            out_o.reg_waddr <= '0;
            out_o.alu_res   <= '0;
            out_o.load_data <= '0;
            out_o.is_load   <= 1'b0;
            out_o.load_kind <= '0;
            out_o.byte_off  <= '0;
            out_o.ebreak    <= 1'b0;
        end else begin
            out_o.valid     <= in_i.valid;
            out_o.reg_wen   <= in_i.reg_wen;
            out_o.reg_waddr <= in_i.reg_waddr;
            out_o.alu_res   <= in_i.alu_res;
            out_o.load_data <= in_i.load_data;  // RAM word sampled at the edge
            out_o.is_load   <= in_i.is_load;
            out_o.load_kind <= in_i.load_kind;
            out_o.byte_off  <= in_i.byte_off;
            out_o.ebreak    <= in_i.ebreak;
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      we_i,
    input  logic [REG_ADDR_WIDTH-1:0] waddr_i,
    input  logic [XLEN-1:0]           wdata_i,
    input  logic [REG_ADDR_WIDTH-1:0] raddr_i,
    output logic [XLEN-1:0]           rdata_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, new value visible right after the write edge
    assign rdata_o = regs[raddr_i];

endmodule

`default_nettype wire

// File: hdl/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    mem_wb_if.consumer                wb,
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr_i,
    output logic [XLEN-1:0]           rs_data_o,
    output logic                      retired_o,
    output logic                      halted_o
);

    dword_u          ld;
    logic [7:0]      lane_b;
    logic [15:0]     lane_h;
    logic [31:0]     lane_w;
    logic [XLEN-1:0] load_val;
    logic [XLEN-1:0] rf_wdata;
    logic            rf_we;
    logic            halted_q;

    assign ld     = wb.load_data;
    assign lane_b = ld.b[wb.byte_off];
    assign lane_h = ld.h[wb.byte_off[2:1]];
    assign lane_w = ld.w[wb.byte_off[2]];

    // sign or zero extension by load kind
    always_comb begin
        case (wb.load_kind)
            LK_B:    load_val = {{(XLEN-8){lane_b[7]}}, lane_b};
            LK_H:    load_val = {{(XLEN-16){lane_h[15]}}, lane_h};
            LK_W:    load_val = {{(XLEN-32){lane_w[31]}}, lane_w};
            LK_BU:   load_val = {{(XLEN-8){1'b0}}, lane_b};
            LK_HU:   load_val = {{(XLEN-16){1'b0}}, lane_h};
            LK_WU:   load_val = {{(XLEN-32){1'b0}}, lane_w};
            LK_D:    load_val = ld.d;
            default: load_val = ld.d;
        endcase
    end

    assign rf_wdata = wb.is_load ? load_val : wb.alu_res;
    assign rf_we    = wb.valid && wb.reg_wen && !wb.ebreak && !halted_q;

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q <= 1'b0;
        end else if (wb.valid && wb.ebreak) begin
            halted_q <= 1'b1;
        end
    end

    assign retired_o = wb.valid && !halted_q;  // the ebreak itself still retires
    assign halted_o  = halted_q;

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .we_i    (rf_we),
        .waddr_i (wb.reg_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

    a_no_retire_halted: assert property (
        @(posedge clk) disable iff (!rst_n) halted_o |-> !retired_o
    ) else $error("wb_stage: instruction retired after halt");

endmodule

`default_nettype wire

// File: hdl/rvseed_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rvseed_mem_wb import rvseed_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_i,
    input  logic [OP_WIDTH-1:0]       op_i,
    input  logic                      reg_wen_i,
    input  logic [REG_ADDR_WIDTH-1:0] rd_i,
    input  logic [XLEN-1:0]           alu_res_i,
    input  logic [XLEN-1:0]           store_data_i,
    input  logic [SZ_WIDTH-1:0]       store_size_i,
    input  logic [LK_WIDTH-1:0]       load_kind_i,
    input  logic                      ebreak_i,
    input  logic [REG_ADDR_WIDTH-1:0] rs_addr_i,
    output logic [XLEN-1:0]           rs_data_o,
    output logic                      retired_o,
    output logic                      halted_o
);

    mem_wb_if mw_q ();  // MEM side, before the pipeline register
    mem_wb_if wb_q ();  // registered bundle into WB

    mem_stage u_mem_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .reg_wen_i    (reg_wen_i),
        .rd_i         (rd_i),
        .alu_res_i    (alu_res_i),
        .store_data_i (store_data_i),
        .store_size_i (store_size_i),
        .load_kind_i  (load_kind_i),
        .ebreak_i     (ebreak_i),
        .mw           (mw_q.producer)
    );

    mem_wb_regs u_mem_wb_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .in_i  (mw_q.consumer),
        .out_o (wb_q.producer)
    );

    wb_stage u_wb_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb        (wb_q.consumer),
        .rs_addr_i (rs_addr_i),
        .rs_data_o (rs_data_o),
        .retired_o (retired_o),
        .halted_o  (halted_o)
    );

endmodule

`default_nettype wire

// File: tb/tb_rvseed_mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rvseed_mem_wb import rvseed_pkg::*; ();

    localparam int N_ALU      = 8;
    localparam int N_RT       = 16;  // eight store/load pairs
    localparam int N_SUB      = 43;  // 14 sub-word stores, 29 loads
    localparam int N_RAND     = 60;
    localparam int N_EBRK     = 4;
    localparam int N_INSNS    = N_ALU + N_RT + N_SUB + N_RAND + N_EBRK;
    localparam int MAX_CYCLES = 4 * N_INSNS + 50;
    localparam logic [XLEN-1:0] REGION = 64'h100;  // nine doublewords used

    logic                      clk;
    logic                      rst_n;
    logic                      valid_i;
    logic [OP_WIDTH-1:0]       op_i;
    logic                      reg_wen_i;
    logic [REG_ADDR_WIDTH-1:0] rd_i;
    logic [XLEN-1:0]           alu_res_i;
    logic [XLEN-1:0]           store_data_i;
    logic [SZ_WIDTH-1:0]       store_size_i;
    logic [LK_WIDTH-1:0]       load_kind_i;
    logic                      ebreak_i;
    logic [REG_ADDR_WIDTH-1:0] rs_addr_i;
    logic [XLEN-1:0]           rs_data_o;
    logic                      retired_o;
    logic                      halted_o;

    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [7:0]      model_mem [2048];  // byte addressed, bits [10:0]
    logic            expect_retire;
    logic            halt_pending;
    string           test_name;
    int              value_errs;
    int              proto_errs;
    int              n_checks;
    int              retire_cnt;
    int              cycles;

    rvseed_mem_wb u_rvseed_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .reg_wen_i    (reg_wen_i),
        .rd_i         (rd_i),
        .alu_res_i    (alu_res_i),
        .store_data_i (store_data_i),
        .store_size_i (store_size_i),
        .load_kind_i  (load_kind_i),
        .ebreak_i     (ebreak_i),
        .rs_addr_i    (rs_addr_i),
        .rs_data_o    (rs_data_o),
        .retired_o    (retired_o),
        .halted_o     (halted_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (retired_o) retire_cnt++;  // pulse is stable mid-cycle
    end

    // retire exactly one cycle after acceptance, nothing after a halt
    a_retire_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && expect_retire) |=> retired_o)
    else begin
        proto_errs++;
        $display("ERROR %s: retired_o expected 1 actual 0", test_name);
    end

    a_no_stray_retire: assert property (@(posedge clk) disable iff (!rst_n)
        !(valid_i && expect_retire) |=> !retired_o)
    else begin
        proto_errs++;
        $display("ERROR %s: retired_o expected 0 actual 1", test_name);
    end

    a_halt_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && ebreak_i && expect_retire) |=> ##1 halted_o)
    else begin
        proto_errs++;
        $display("ERROR %s: halted_o expected 1 actual 0 after ebreak", test_name);
    end

    a_halt_held: assert property (@(posedge clk) disable iff (!rst_n)
        halted_o |=> halted_o)
    else begin
        proto_errs++;
        $display("ERROR %s: halted_o dropped before reset", test_name);
    end

    a_no_early_halt: assert property (@(posedge clk) disable iff (!rst_n)
        !halt_pending |-> !halted_o)
    else begin
        proto_errs++;
        $display("ERROR %s: halted_o rose with no ebreak issued", test_name);
    end

    function automatic int kind_bytes(logic [LK_WIDTH-1:0] kind);
        case (kind)
            LK_B, LK_BU: return 1;
            LK_H, LK_HU: return 2;
            LK_W, LK_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic [LK_WIDTH-1:0] kind_for(logic [SZ_WIDTH-1:0] sz, bit uns);
        case (sz)
            SZ_B:    return uns ? LK_BU : LK_B;
            SZ_H:    return uns ? LK_HU : LK_H;
            SZ_W:    return uns ? LK_WU : LK_W;
            default: return LK_D;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // random naturally aligned address inside the initialized region
    function automatic logic [XLEN-1:0] rand_addr(int n);
        return REGION + 8 * $urandom_range(8, 0) + ($urandom_range(7, 0) & ~(n - 1));
    endfunction

    function automatic void model_store(logic [XLEN-1:0] addr, logic [XLEN-1:0] data,
                                        logic [SZ_WIDTH-1:0] size);
        int n;
        n = 1 << size;
        for (int i = 0; i < n; i++) model_mem[addr[10:0] + i] = data[8*i +: 8];
    endfunction

    function automatic logic [XLEN-1:0] model_load(logic [XLEN-1:0] addr,
                                                   logic [LK_WIDTH-1:0] kind);
        int n;
        logic [XLEN-1:0] v;
        logic sgn;
        n = kind_bytes(kind);
        v = '0;
        for (int i = 0; i < n; i++) v[8*i +: 8] = model_mem[addr[10:0] + i];
        sgn = (kind == LK_B || kind == LK_H || kind == LK_W) && v[8*n-1];
        for (int i = 8 * n; i < XLEN; i++) v[i] = sgn;
        return v;
    endfunction

    // one instruction for one cycle, model updated in program order
    task automatic issue(input logic [OP_WIDTH-1:0] op, input logic [REG_ADDR_WIDTH-1:0] rd,
                         input logic wen, input logic [XLEN-1:0] res,
                         input logic [XLEN-1:0] sdata, input logic [SZ_WIDTH-1:0] size,
                         input logic [LK_WIDTH-1:0] kind, input logic ebrk);
        valid_i       = 1'b1;
        op_i          = op;
        reg_wen_i     = wen;
        rd_i          = rd;
        alu_res_i     = res;
        store_data_i  = sdata;
        store_size_i  = size;
        load_kind_i   = kind;
        ebreak_i      = ebrk;
        expect_retire = !halt_pending;
        if (!halt_pending && !ebrk && wen && rd != '0) begin
            if (op == OP_ALU) model_regs[rd] = res;
            else if (op == OP_LOAD) model_regs[rd] = model_load(res, kind);
        end
        if (op == OP_STORE) model_store(res, sdata, size);
        if (ebrk) halt_pending = 1'b1;
        @(posedge clk);
        #1;
        valid_i  = 1'b0;
        ebreak_i = 1'b0;
    endtask

    task automatic alu_write(input logic [REG_ADDR_WIDTH-1:0] rd, input logic [XLEN-1:0] v);
        issue(OP_ALU, rd, 1'b1, v, '0, SZ_D, LK_D, 1'b0);
    endtask

    task automatic load_reg(input logic [REG_ADDR_WIDTH-1:0] rd, input logic [XLEN-1:0] a,
                            input logic [LK_WIDTH-1:0] kind);
        issue(OP_LOAD, rd, 1'b1, a, '0, SZ_D, kind, 1'b0);
    endtask

    // x7 with reg_wen set, a store must still leave it alone
    task automatic store_mem(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d,
                             input logic [SZ_WIDTH-1:0] size);
        issue(OP_STORE, 5'd7, 1'b1, a, d, size, LK_D, 1'b0);
    endtask

    task automatic drain();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        n_checks++;
        assert (act === exp) else begin
            value_errs++;
            $display("ERROR %s: %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input int r);
        rs_addr_i = REG_ADDR_WIDTH'(r);
        @(negedge clk);
        check_value($sformatf("x%0d", r), model_regs[r], rs_data_o);
        @(posedge clk);
        #1;
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < NUM_REGS; r++) check_reg(r);
    endtask

    task automatic wrap_up(input bit timed_out);
        $display("checks %0d, value errors %0d, protocol errors %0d",
                 n_checks, value_errs, proto_errs);
        if (!timed_out && value_errs == 0 && proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        wrap_up(1'b1);
    end

    initial begin
        int alu_rd [N_ALU];
        logic [XLEN-1:0] d;
        logic [SZ_WIDTH-1:0] sz;
        logic [LK_WIDTH-1:0] kind;
        int n;
        int sel;
        int base;
        void'($urandom(32'h7bab));
        alu_rd = '{0, 1, 2, 3, 5, 8, 13, 31};
        {valid_i, op_i, reg_wen_i, rd_i, alu_res_i, store_data_i} = '0;
        {store_size_i, load_kind_i, ebreak_i, rs_addr_i} = '0;
        {expect_retire, halt_pending} = '0;
        {value_errs, proto_errs, n_checks, retire_cnt} = '0;
        for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
        test_name = "reset";
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value("retired_o", '0, retired_o);
        check_value("halted_o", '0, halted_o);
        drain();
        check_all_regs();

        test_name = "alu_writeback";
        for (int i = 0; i < N_ALU; i++) begin
            alu_write(alu_rd[i], rand64());
            drain();
            check_reg(alu_rd[i]);
        end

        test_name = "dword_round_trip";  // load right behind each store
        for (int k = 0; k < N_RT / 2; k++) begin
            d = rand64();
            store_mem(REGION + 8 * k, d, SZ_D);
            load_reg(REG_ADDR_WIDTH'(k + 1), REGION + 8 * k, LK_D);
        end
        drain();
        for (int k = 0; k < N_RT / 2; k++) check_reg(k + 1);

        test_name = "subword";
        for (int s = 0; s < 3; s++) begin
            sz = SZ_WIDTH'(s);
            n  = 1 << s;
            for (int off = 0; off < 8; off += n) begin
                d = rand64();
                d[8*n-1] = ((off / n) % 2) != 0;  // alternate lane sign
                store_mem(REGION + 64 + off, d, sz);
            end
            for (int u = 0; u < 2; u++) begin
                for (int off = 0; off < 8; off += n) begin
                    load_reg(5'd10, REGION + 64 + off, kind_for(sz, u != 0));
                    drain();
                    check_reg(10);
                end
            end
        end
        load_reg(5'd11, REGION + 64, LK_D);
        drain();
        check_reg(11);

        test_name = "pipelined_random";
        base = retire_cnt;
        for (int i = 0; i < N_RAND; i++) begin
            sel = $urandom_range(2, 0);
            if (sel == 0) begin
                issue(OP_ALU, 5'($urandom_range(31, 0)), $urandom_range(3, 0) != 0,
                      rand64(), '0, SZ_D, LK_D, 1'b0);
            end else if (sel == 1) begin
                kind = 3'($urandom_range(6, 0));
                load_reg(5'($urandom_range(31, 0)), rand_addr(kind_bytes(kind)), kind);
            end else begin
                sz = 2'($urandom_range(3, 0));
                store_mem(rand_addr(1 << sz), rand64(), sz);
            end
        end
        drain();
        check_value("retire count", XLEN'(N_RAND), XLEN'(retire_cnt - base));
        check_all_regs();

        test_name = "ebreak";
        alu_write(5'd20, rand64());
        issue(OP_ALU, 5'd21, 1'b1, rand64(), '0, SZ_D, LK_D, 1'b1);
        alu_write(5'd20, rand64());  // must be dropped
        load_reg(5'd21, REGION, LK_D);
        drain();
        drain();
        @(negedge clk);
        check_value("halted_o", 64'd1, {63'd0, halted_o});
        drain();
        check_reg(20);
        check_reg(21);
        wrap_up(1'b0);
    end

endmodule

`default_nettype wire

// File: rvseed_mem_wb.f
common/rvseed_pkg.sv
common/mem_wb_if.sv
hdl/data_ram.sv
hdl/mem_stage.sv
hdl/mem_wb_regs.sv
hdl/reg_file.sv
hdl/wb_stage.sv
hdl/rvseed_mem_wb.sv
tb/tb_rvseed_mem_wb.sv
